/* hw/thumb_ctrl_pkg.sv */
package thumb_ctrl_pkg;

    localparam int INSTR_W     = 16;
    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 4;
    localparam int LOW_REG_CNT = 8;
    localparam int WORD_BYTES  = 4;

    // instruction families, classified from bits 15 down to 10
    typedef enum logic [3:0] {
        GRP_SHIFT_IMM,
        GRP_DATA_PROC,
        GRP_LS_IMM,
        GRP_LS_BYTE,
        GRP_LS_HALF,
        GRP_LS_SP,
        GRP_STM,
        GRP_LDM,
        GRP_UNKNOWN
    } op_group_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BIC,
        ALU_NOT,
        ALU_MUL,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR,
        ALU_ADC,
        ALU_SBC
    } alu_op_e;

    // SRC_OFFSET selects the immediate that the controller itself produces
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_OFFSET
    } alu_src_e;

    typedef enum logic {
        DATA_FROM_ALU,
        DATA_FROM_MEM
    } reg_data_src_e;

    typedef enum logic {
        ADDR_FROM_INSTR,
        ADDR_FROM_CTRL
    } addr_src_e;

    typedef enum logic {
        SEL_REG_2,
        SEL_REG_3
    } reg_b_sel_e;

    typedef enum logic [1:0] {
        BLOCK_NONE,
        BLOCK_STM_ASC,
        BLOCK_LDM_DESC
    } block_op_e;

    function automatic op_group_e group_of(input logic [INSTR_W-1:0] instr);
        op_group_e group;
        casez (instr[15:10])
            6'b00????: group = GRP_SHIFT_IMM;
            6'b010000: group = GRP_DATA_PROC;
            6'b0110??: group = GRP_LS_IMM;
            6'b0111??: group = GRP_LS_BYTE;
            6'b1000??: group = GRP_LS_HALF;
            6'b1001??: group = GRP_LS_SP;
            6'b11000?: group = GRP_STM;
            6'b11001?: group = GRP_LDM;
            default:   group = GRP_UNKNOWN;
        endcase
        return group;
    endfunction

    // the scan runs downwards so the last hit is the lowest set bit
    function automatic logic [REG_ADDR_W-1:0] lowest_set(input logic [LOW_REG_CNT-1:0] list);
        logic [REG_ADDR_W-1:0] idx;
        idx = '0;
        for (int i = LOW_REG_CNT - 1; i >= 0; i--) begin
            if (list[i]) begin
                idx = REG_ADDR_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] highest_set(input logic [LOW_REG_CNT-1:0] list);
        logic [REG_ADDR_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < LOW_REG_CNT; i++) begin
            if (list[i]) begin
                idx = REG_ADDR_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [$clog2(LOW_REG_CNT+1)-1:0] pop_count(
        input logic [LOW_REG_CNT-1:0] list
    );
        logic [$clog2(LOW_REG_CNT+1)-1:0] sum;
        sum = '0;
        for (int i = 0; i < LOW_REG_CNT; i++) begin
            if (list[i]) begin
                sum = sum + 1'b1;
            end
        end
        return sum;
    endfunction

endpackage

/* hw/op_decoder.sv */
`timescale 1ns/1ps

module op_decoder (
    input  logic                                       valid_i,
    input  logic [thumb_ctrl_pkg::INSTR_W-1:0]         instruction_i,
    input  logic                                       seq_busy_i,
    input  logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]      seq_reg_i,
    input  logic [thumb_ctrl_pkg::WORD_W-1:0]          seq_offset_i,

    output thumb_ctrl_pkg::block_op_e                  block_op_o,
    output logic                                       valid_o,
    output logic                                       update_flag_o,
    output logic                                       mem_read_en_o,
    output logic                                       mem_write_en_o,
    output logic                                       reg_write_en_o,
    output thumb_ctrl_pkg::reg_data_src_e              reg_data_src_o,
    output thumb_ctrl_pkg::alu_src_e                   alu_src_a_o,
    output thumb_ctrl_pkg::alu_src_e                   alu_src_b_o,
    output thumb_ctrl_pkg::alu_op_e                    alu_op_o,
    output logic                                       stall_o,
    output thumb_ctrl_pkg::addr_src_e                  reg_addr_b_src_o,
    output thumb_ctrl_pkg::addr_src_e                  reg_dest_src_o,
    output thumb_ctrl_pkg::reg_b_sel_e                 reg_b_sel_o,
    output logic [thumb_ctrl_pkg::WORD_W-1:0]          offset_imm_o,
    output logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]      ctrl_reg_addr_o
);

    thumb_ctrl_pkg::op_group_e                   group;
    logic [4:0]                                  shift_code;
    logic [3:0]                                  dp_code;
    logic [thumb_ctrl_pkg::LOW_REG_CNT-1:0]      reg_list;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]       base_reg;
    logic                                        base_in_list;

    assign group        = thumb_ctrl_pkg::group_of(instruction_i);
    assign shift_code   = instruction_i[13:9];
    assign dp_code      = instruction_i[9:6];
    assign reg_list     = instruction_i[thumb_ctrl_pkg::LOW_REG_CNT-1:0];
    assign base_reg     = thumb_ctrl_pkg::REG_ADDR_W'(instruction_i[10:8]);
    assign base_in_list = reg_list[instruction_i[10:8]];

    // the sequencer only runs while a valid block transfer is presented
    always_comb begin
        block_op_o = thumb_ctrl_pkg::BLOCK_NONE;
        if (valid_i && group == thumb_ctrl_pkg::GRP_STM) begin
            block_op_o = thumb_ctrl_pkg::BLOCK_STM_ASC;
        end else if (valid_i && group == thumb_ctrl_pkg::GRP_LDM) begin
            block_op_o = thumb_ctrl_pkg::BLOCK_LDM_DESC;
        end
    end

    always_comb begin
        valid_o          = valid_i;
        update_flag_o    = 1'b0;
        mem_read_en_o    = 1'b0;
        mem_write_en_o   = 1'b0;
        reg_write_en_o   = 1'b0;
        reg_data_src_o   = thumb_ctrl_pkg::DATA_FROM_ALU;
        alu_src_a_o      = thumb_ctrl_pkg::SRC_REG;
        alu_src_b_o      = thumb_ctrl_pkg::SRC_REG;
        alu_op_o         = thumb_ctrl_pkg::ALU_ADD;
        stall_o          = 1'b0;
        reg_addr_b_src_o = thumb_ctrl_pkg::ADDR_FROM_INSTR;
        reg_dest_src_o   = thumb_ctrl_pkg::ADDR_FROM_INSTR;
        reg_b_sel_o      = thumb_ctrl_pkg::SEL_REG_2;
        offset_imm_o     = '0;
        ctrl_reg_addr_o  = '0;

        case (group)
            thumb_ctrl_pkg::GRP_SHIFT_IMM: begin
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                casez (shift_code)
                    5'b000??: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_LSL;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    5'b001??: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_LSR;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    5'b010??: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_ASR;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    5'b01101: alu_op_o = thumb_ctrl_pkg::ALU_SUB;
                    5'b01110, 5'b110??: alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    5'b01111, 5'b111??: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    // move adds the immediate to zero
                    5'b100??: begin
                        alu_src_a_o = thumb_ctrl_pkg::SRC_ZERO;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    5'b101??: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_b_o    = thumb_ctrl_pkg::SRC_IMM;
                        reg_write_en_o = 1'b0;
                    end
                    default: alu_op_o = thumb_ctrl_pkg::ALU_ADD;
                endcase
            end
            thumb_ctrl_pkg::GRP_DATA_PROC: begin
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                case (dp_code)
                    4'b0000: alu_op_o = thumb_ctrl_pkg::ALU_AND;
                    4'b0001: alu_op_o = thumb_ctrl_pkg::ALU_XOR;
                    4'b0010: alu_op_o = thumb_ctrl_pkg::ALU_LSL;
                    4'b0011: alu_op_o = thumb_ctrl_pkg::ALU_LSR;
                    4'b0100: alu_op_o = thumb_ctrl_pkg::ALU_ASR;
                    4'b0101: alu_op_o = thumb_ctrl_pkg::ALU_ADC;
                    4'b0110: alu_op_o = thumb_ctrl_pkg::ALU_SBC;
                    4'b0111: alu_op_o = thumb_ctrl_pkg::ALU_ROR;
                    // test only sets the flags of the and
                    4'b1000: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_AND;
                        reg_write_en_o = 1'b0;
                    end
                    4'b1001: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_a_o = thumb_ctrl_pkg::SRC_ZERO;
                    end
                    4'b1010: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_SUB;
                        reg_write_en_o = 1'b0;
                    end
                    4'b1011: reg_write_en_o = 1'b0;
                    4'b1100: alu_op_o = thumb_ctrl_pkg::ALU_OR;
                    4'b1101: alu_op_o = thumb_ctrl_pkg::ALU_MUL;
                    4'b1110: alu_op_o = thumb_ctrl_pkg::ALU_BIC;
                    default: alu_op_o = thumb_ctrl_pkg::ALU_NOT;
                endcase
            end
            thumb_ctrl_pkg::GRP_LS_IMM, thumb_ctrl_pkg::GRP_LS_BYTE,
            thumb_ctrl_pkg::GRP_LS_HALF, thumb_ctrl_pkg::GRP_LS_SP: begin
                alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                // bit 11 is the load bit in all four immediate forms
                if (instruction_i[11]) begin
                    mem_read_en_o  = 1'b1;
                    reg_write_en_o = 1'b1;
                    reg_data_src_o = thumb_ctrl_pkg::DATA_FROM_MEM;
                end else begin
                    mem_write_en_o = 1'b1;
                    reg_b_sel_o    = thumb_ctrl_pkg::SEL_REG_3;
                end
            end
            thumb_ctrl_pkg::GRP_STM: begin
                stall_o      = seq_busy_i;
                alu_src_b_o  = thumb_ctrl_pkg::SRC_OFFSET;
                offset_imm_o = seq_offset_i;
                if (seq_busy_i) begin
                    mem_write_en_o   = 1'b1;
                    reg_addr_b_src_o = thumb_ctrl_pkg::ADDR_FROM_CTRL;
                    ctrl_reg_addr_o  = seq_reg_i;
                end else begin
                    reg_write_en_o  = 1'b1;
                    reg_dest_src_o  = thumb_ctrl_pkg::ADDR_FROM_CTRL;
                    ctrl_reg_addr_o = base_reg;
                end
            end
            thumb_ctrl_pkg::GRP_LDM: begin
                stall_o        = seq_busy_i;
                alu_src_b_o    = thumb_ctrl_pkg::SRC_OFFSET;
                offset_imm_o   = seq_offset_i;
                reg_dest_src_o = thumb_ctrl_pkg::ADDR_FROM_CTRL;
                if (seq_busy_i) begin
                    mem_read_en_o   = 1'b1;
                    reg_write_en_o  = 1'b1;
                    reg_data_src_o  = thumb_ctrl_pkg::DATA_FROM_MEM;
                    ctrl_reg_addr_o = seq_reg_i;
                end else begin
                    // a loaded base keeps its loaded value
                    reg_write_en_o  = !base_in_list;
                    ctrl_reg_addr_o = base_reg;
                end
            end
            default: valid_o = 1'b0;
        endcase

        if (!valid_i) begin
            update_flag_o  = 1'b0;
            mem_read_en_o  = 1'b0;
            mem_write_en_o = 1'b0;
            reg_write_en_o = 1'b0;
        end
    end

endmodule

/* hw/reg_list_sequencer.sv */
`timescale 1ns/1ps

module reg_list_sequencer #(
    parameter int unsigned LIST_W = thumb_ctrl_pkg::LOW_REG_CNT
) (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  thumb_ctrl_pkg::block_op_e              block_op_i,
    input  logic [LIST_W-1:0]                      list_i,

    output logic                                   busy_o,
    output logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]  cur_reg_o,
    output logic [thumb_ctrl_pkg::WORD_W-1:0]      offset_o
);

    localparam int unsigned CNT_W = $clog2(thumb_ctrl_pkg::LOW_REG_CNT + 1);

    // a set bit marks a register that still has to be transferred
    logic [LIST_W-1:0] remaining_q;
    logic [CNT_W-1:0]  step_q;

    logic [LIST_W-1:0] pending;
    logic [LIST_W-1:0] cur_onehot;
    logic [CNT_W-1:0]  list_cnt;
    logic              active;

    assign active   = (block_op_i != thumb_ctrl_pkg::BLOCK_NONE);
    assign pending  = list_i & remaining_q;
    assign busy_o   = active && (pending != '0);
    assign list_cnt = thumb_ctrl_pkg::pop_count(thumb_ctrl_pkg::LOW_REG_CNT'(list_i));

    // stores walk upwards, loads walk downwards
    always_comb begin
        if (block_op_i == thumb_ctrl_pkg::BLOCK_LDM_DESC) begin
            cur_reg_o = thumb_ctrl_pkg::highest_set(thumb_ctrl_pkg::LOW_REG_CNT'(pending));
        end else begin
            cur_reg_o = thumb_ctrl_pkg::lowest_set(thumb_ctrl_pkg::LOW_REG_CNT'(pending));
        end
    end

    assign cur_onehot = LIST_W'(1) << cur_reg_o;

    // the final cycle always points one past the whole block
    always_comb begin
        if (!busy_o) begin
            offset_o = thumb_ctrl_pkg::WORD_W'(thumb_ctrl_pkg::WORD_BYTES * list_cnt);
        end else if (block_op_i == thumb_ctrl_pkg::BLOCK_LDM_DESC) begin
            offset_o = thumb_ctrl_pkg::WORD_W'(
                thumb_ctrl_pkg::WORD_BYTES * (list_cnt - step_q - 1'b1));
        end else begin
            offset_o = thumb_ctrl_pkg::WORD_W'(thumb_ctrl_pkg::WORD_BYTES * step_q);
        end
    end

    // the walk restarts once the final cycle ends or the transfer is dropped
    always_ff @(posedge clk_i) begin
        if (reset_i || !busy_o) begin
            remaining_q <= '1;
            step_q      <= '0;
        end else begin
            remaining_q <= remaining_q & ~cur_onehot;
            step_q      <= step_q + 1'b1;
        end
    end

endmodule

/* hw/thumb_ctrl.sv */
`timescale 1ns/1ps

module thumb_ctrl #(
    parameter int unsigned LIST_W = thumb_ctrl_pkg::LOW_REG_CNT
) (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   valid_i,
    input  logic [thumb_ctrl_pkg::INSTR_W-1:0]     instruction_i,

    output logic                                   valid_o,
    output logic                                   update_flag_o,
    output logic                                   mem_read_en_o,
    output logic                                   mem_write_en_o,
    output logic                                   reg_write_en_o,
    output thumb_ctrl_pkg::reg_data_src_e          reg_data_src_o,
    output thumb_ctrl_pkg::alu_src_e               alu_src_a_o,
    output thumb_ctrl_pkg::alu_src_e               alu_src_b_o,
    output thumb_ctrl_pkg::alu_op_e                alu_op_o,
    output logic                                   stall_o,
    output thumb_ctrl_pkg::addr_src_e              reg_addr_b_src_o,
    output thumb_ctrl_pkg::addr_src_e              reg_dest_src_o,
    output thumb_ctrl_pkg::reg_b_sel_e             reg_b_sel_o,
    output logic [thumb_ctrl_pkg::WORD_W-1:0]      offset_imm_o,
    output logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]  ctrl_reg_addr_o
);

    thumb_ctrl_pkg::block_op_e                  block_op;
    logic                                       seq_busy;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]      seq_reg;
    logic [thumb_ctrl_pkg::WORD_W-1:0]          seq_offset;

    op_decoder i_op_decoder (
        .valid_i          (valid_i),
        .instruction_i    (instruction_i),
        .seq_busy_i       (seq_busy),
        .seq_reg_i        (seq_reg),
        .seq_offset_i     (seq_offset),
        .block_op_o       (block_op),
        .valid_o          (valid_o),
        .update_flag_o    (update_flag_o),
        .mem_read_en_o    (mem_read_en_o),
        .mem_write_en_o   (mem_write_en_o),
        .reg_write_en_o   (reg_write_en_o),
        .reg_data_src_o   (reg_data_src_o),
        .alu_src_a_o      (alu_src_a_o),
        .alu_src_b_o      (alu_src_b_o),
        .alu_op_o         (alu_op_o),
        .stall_o          (stall_o),
        .reg_addr_b_src_o (reg_addr_b_src_o),
        .reg_dest_src_o   (reg_dest_src_o),
        .reg_b_sel_o      (reg_b_sel_o),
        .offset_imm_o     (offset_imm_o),
        .ctrl_reg_addr_o  (ctrl_reg_addr_o)
    );

    // the register list sits in the low byte of the block-transfer encoding
    reg_list_sequencer #(
        .LIST_W (LIST_W)
    ) i_reg_list_sequencer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .block_op_i (block_op),
        .list_i     (instruction_i[LIST_W-1:0]),
        .busy_o     (seq_busy),
        .cur_reg_o  (seq_reg),
        .offset_o   (seq_offset)
    );

endmodule

/* testbench/tb_thumb_ctrl.sv */
`timescale 1ns/1ps

module tb_thumb_ctrl;

    localparam int CLK_HALF      = 4;
    localparam int SAMPLE_DELAY  = 3;
    localparam int STALL_LIMIT   = 20;
    localparam int RANDOM_BLOCKS = 40;
    localparam int FIELD_CNT     = 14;

    logic                                   clk_i;
    logic                                   reset_i;
    logic                                   valid_i;
    logic [thumb_ctrl_pkg::INSTR_W-1:0]     instruction_i;

    logic                                   valid_o;
    logic                                   update_flag_o;
    logic                                   mem_read_en_o;
    logic                                   mem_write_en_o;
    logic                                   reg_write_en_o;
    thumb_ctrl_pkg::reg_data_src_e          reg_data_src_o;
    thumb_ctrl_pkg::alu_src_e               alu_src_a_o;
    thumb_ctrl_pkg::alu_src_e               alu_src_b_o;
    thumb_ctrl_pkg::alu_op_e                alu_op_o;
    logic                                   stall_o;
    thumb_ctrl_pkg::addr_src_e              reg_addr_b_src_o;
    thumb_ctrl_pkg::addr_src_e              reg_dest_src_o;
    thumb_ctrl_pkg::reg_b_sel_e             reg_b_sel_o;
    logic [thumb_ctrl_pkg::WORD_W-1:0]      offset_imm_o;
    logic [thumb_ctrl_pkg::REG_ADDR_W-1:0]  ctrl_reg_addr_o;

    logic [15:0] lfsr_state;
    int          vector_count;

    thumb_ctrl #(
        .LIST_W (thumb_ctrl_pkg::LOW_REG_CNT)
    ) i_dut (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .valid_i          (valid_i),
        .instruction_i    (instruction_i),
        .valid_o          (valid_o),
        .update_flag_o    (update_flag_o),
        .mem_read_en_o    (mem_read_en_o),
        .mem_write_en_o   (mem_write_en_o),
        .reg_write_en_o   (reg_write_en_o),
        .reg_data_src_o   (reg_data_src_o),
        .alu_src_a_o      (alu_src_a_o),
        .alu_src_b_o      (alu_src_b_o),
        .alu_op_o         (alu_op_o),
        .stall_o          (stall_o),
        .reg_addr_b_src_o (reg_addr_b_src_o),
        .reg_dest_src_o   (reg_dest_src_o),
        .reg_b_sel_o      (reg_b_sel_o),
        .offset_imm_o     (offset_imm_o),
        .ctrl_reg_addr_o  (ctrl_reg_addr_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR: %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
            $display("Test failures found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[14:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    // one vector line is one clock cycle
    task automatic replay_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] v_valid, v_instr, e_stall, e_rw, e_mw, e_mr, e_upd, e_valid;
        logic [31:0] e_op, e_src_a, e_b_sel, e_dsrc, e_addr, e_off;
        thumb_ctrl_pkg::alu_op_e       exp_op;
        thumb_ctrl_pkg::alu_src_e      exp_src_a;
        thumb_ctrl_pkg::reg_b_sel_e    exp_b_sel;
        thumb_ctrl_pkg::reg_data_src_e exp_dsrc;
        fd = $fopen("testbench/thumb_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/thumb_ctrl_vectors.txt for reading");
            $display("Test failures found");
            $fatal(1, "vector file missing");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             v_valid, v_instr, e_stall, e_rw, e_mw, e_mr, e_upd, e_valid,
                             e_op, e_src_a, e_b_sel, e_dsrc, e_addr, e_off);
            if (fields == FIELD_CNT) begin
                exp_op    = thumb_ctrl_pkg::alu_op_e'(e_op[3:0]);
                exp_src_a = thumb_ctrl_pkg::alu_src_e'(e_src_a[1:0]);
                exp_b_sel = thumb_ctrl_pkg::reg_b_sel_e'(e_b_sel[0]);
                exp_dsrc  = thumb_ctrl_pkg::reg_data_src_e'(e_dsrc[0]);
                @(negedge clk_i);
                valid_i       = v_valid[0];
                instruction_i = v_instr[15:0];
                #(SAMPLE_DELAY);
                check_value("stall_o", e_stall, stall_o);
                check_value("reg_write_en_o", e_rw, reg_write_en_o);
                check_value("mem_write_en_o", e_mw, mem_write_en_o);
                check_value("mem_read_en_o", e_mr, mem_read_en_o);
                check_value("update_flag_o", e_upd, update_flag_o);
                check_value("valid_o", e_valid, valid_o);
                check_value("alu_op_o", exp_op, alu_op_o);
                check_value("alu_src_a_o", exp_src_a, alu_src_a_o);
                check_value("reg_b_sel_o", exp_b_sel, reg_b_sel_o);
                check_value("reg_data_src_o", exp_dsrc, reg_data_src_o);
                check_value("ctrl_reg_addr_o", e_addr, ctrl_reg_addr_o);
                check_value("offset_imm_o", e_off, offset_imm_o);
                vector_count++;
            end
        end
        $fclose(fd);
        if (vector_count == 0) begin
            $display("the vector file held no usable lines");
            $display("Test failures found");
            $fatal(1, "no vectors");
        end
    endtask

    task automatic run_block_transfer();
        logic [15:0] bits;
        logic [7:0]  list;
        logic [2:0]  base;
        logic        is_load;
        logic [3:0]  order [8];
        int          n;
        int          k;
        int          idx;
        thumb_ctrl_pkg::addr_src_e     busy_b_src;
        thumb_ctrl_pkg::addr_src_e     busy_dest_src;
        thumb_ctrl_pkg::reg_data_src_e busy_dsrc;
        draw_bits(8, bits);
        list = bits[7:0];
        draw_bits(3, bits);
        base = bits[2:0];
        draw_bits(1, bits);
        is_load = bits[0];

        // stores read the listed register on port b, loads write it
        if (is_load) begin
            busy_b_src    = thumb_ctrl_pkg::ADDR_FROM_INSTR;
            busy_dest_src = thumb_ctrl_pkg::ADDR_FROM_CTRL;
            busy_dsrc     = thumb_ctrl_pkg::DATA_FROM_MEM;
        end else begin
            busy_b_src    = thumb_ctrl_pkg::ADDR_FROM_CTRL;
            busy_dest_src = thumb_ctrl_pkg::ADDR_FROM_INSTR;
            busy_dsrc     = thumb_ctrl_pkg::DATA_FROM_ALU;
        end

        // loads visit the list from the top, stores from the bottom
        n = 0;
        for (int i = 0; i < 8; i++) begin
            idx = is_load ? 7 - i : i;
            if (list[idx]) begin
                order[n] = idx[3:0];
                n++;
            end
        end

        @(negedge clk_i);
        valid_i       = 1'b1;
        instruction_i = {4'b1100, is_load, base, list};
        #(SAMPLE_DELAY);
        k = 0;
        while (stall_o === 1'b1 && k < STALL_LIMIT) begin
            check_value("stall_o", (k < n), stall_o);
            check_value("ctrl_reg_addr_o", order[k], ctrl_reg_addr_o);
            check_value("offset_imm_o", is_load ? 4 * (n - 1 - k) : 4 * k, offset_imm_o);
            check_value("mem_write_en_o", !is_load, mem_write_en_o);
            check_value("mem_read_en_o", is_load, mem_read_en_o);
            check_value("reg_write_en_o", is_load, reg_write_en_o);
            check_value("reg_data_src_o", busy_dsrc, reg_data_src_o);
            check_value("alu_src_b_o", thumb_ctrl_pkg::SRC_OFFSET, alu_src_b_o);
            check_value("reg_addr_b_src_o", busy_b_src, reg_addr_b_src_o);
            check_value("reg_dest_src_o", busy_dest_src, reg_dest_src_o);
            k++;
            @(negedge clk_i);
            #(SAMPLE_DELAY);
        end
        if (stall_o === 1'b1) begin
            $display("timeout: stall_o stayed high for %0d cycles on a block transfer",
                     STALL_LIMIT);
            $display("Test failures found");
            $fatal(1, "block transfer never finished");
        end

        // the final cycle writes the updated base back
        check_value("stall_o cycles", n, k);
        check_value("ctrl_reg_addr_o", base, ctrl_reg_addr_o);
        check_value("offset_imm_o", 4 * n, offset_imm_o);
        check_value("reg_write_en_o", is_load ? !list[base] : 1'b1, reg_write_en_o);
        check_value("mem_write_en_o", 0, mem_write_en_o);
        check_value("mem_read_en_o", 0, mem_read_en_o);
        check_value("reg_data_src_o", thumb_ctrl_pkg::DATA_FROM_ALU, reg_data_src_o);
        check_value("alu_src_b_o", thumb_ctrl_pkg::SRC_OFFSET, alu_src_b_o);
        check_value("reg_addr_b_src_o", thumb_ctrl_pkg::ADDR_FROM_INSTR, reg_addr_b_src_o);
        check_value("reg_dest_src_o", thumb_ctrl_pkg::ADDR_FROM_CTRL, reg_dest_src_o);
    endtask

    initial begin
        clk_i         = 1'b0;
        reset_i       = 1'b1;
        valid_i       = 1'b0;
        instruction_i = '0;
        lfsr_state    = 16'd54;
        vector_count  = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        replay_vectors();
        for (int i = 0; i < RANDOM_BLOCKS; i++) begin
            run_block_transfer();
        end

        @(negedge clk_i);
        valid_i = 1'b0;
        $display("All tests passed!");
        $finish;
    end

endmodule

/* testbench/thumb_ctrl_vectors.txt */
# valid instr | stall reg_wr mem_wr mem_rd upd_flag valid_o | alu_op src_a b_sel data_src | reg offset
# one line per clock cycle, all fields in hex, enum fields given by their encodings
0 0000 0 0 0 0 0 0 8 0 0 0 0 00000000
0 C125 0 0 0 0 0 0 0 0 0 0 1 0000000C
1 00D1 0 1 0 0 1 1 8 0 0 0 0 00000000
1 0851 0 1 0 0 1 1 9 0 0 0 0 00000000
1 1888 0 1 0 0 1 1 0 0 0 0 0 00000000
1 1A88 0 1 0 0 1 1 1 0 0 0 0 00000000
1 2105 0 1 0 0 1 1 0 2 0 0 0 00000000
1 2A07 0 0 0 0 1 1 1 0 0 0 0 00000000
1 3805 0 1 0 0 1 1 1 0 0 0 0 00000000
1 4011 0 1 0 0 1 1 2 0 0 0 0 00000000
1 4211 0 0 0 0 1 1 2 0 0 0 0 00000000
1 4291 0 0 0 0 1 1 1 0 0 0 0 00000000
1 4251 0 1 0 0 1 1 1 2 0 0 0 00000000
1 4351 0 1 0 0 1 1 7 0 0 0 0 00000000
1 43D1 0 1 0 0 1 1 6 0 0 0 0 00000000
1 6851 0 1 0 1 0 1 0 0 0 1 0 00000000
1 6051 0 0 1 0 0 1 0 0 1 0 0 00000000
1 7051 0 0 1 0 0 1 0 0 1 0 0 00000000
1 8851 0 1 0 1 0 1 0 0 0 1 0 00000000
1 9204 0 0 1 0 0 1 0 0 1 0 0 00000000
1 B500 0 0 0 0 0 0 0 0 0 0 0 00000000
1 C125 1 0 1 0 0 1 0 0 0 0 0 00000000
1 C125 1 0 1 0 0 1 0 0 0 0 2 00000004
1 C125 1 0 1 0 0 1 0 0 0 0 5 00000008
1 C125 0 1 0 0 0 1 0 0 0 0 1 0000000C
1 CB52 1 1 0 1 0 1 0 0 0 1 6 00000008
1 CB52 1 1 0 1 0 1 0 0 0 1 4 00000004
1 CB52 1 1 0 1 0 1 0 0 0 1 1 00000000
1 CB52 0 1 0 0 0 1 0 0 0 0 3 0000000C
1 CA84 1 1 0 1 0 1 0 0 0 1 7 00000004
1 CA84 1 1 0 1 0 1 0 0 0 1 2 00000000
1 CA84 0 0 0 0 0 1 0 0 0 0 2 00000008
1 C800 0 1 0 0 0 1 0 0 0 0 0 00000000
1 C40A 1 0 1 0 0 1 0 0 0 0 1 00000000
0 C40A 0 0 0 0 0 0 0 0 0 0 4 00000008
1 C40A 1 0 1 0 0 1 0 0 0 0 1 00000000
1 C40A 1 0 1 0 0 1 0 0 0 0 3 00000004
1 C40A 0 1 0 0 0 1 0 0 0 0 4 00000008
0 0000 0 0 0 0 0 0 8 0 0 0 0 00000000

/* src.f */
hw/thumb_ctrl_pkg.sv
hw/op_decoder.sv
hw/reg_list_sequencer.sv
hw/thumb_ctrl.sv
testbench/tb_thumb_ctrl.sv

/* Bender.yml */
package:
  name: thumb_ctrl

sources:
  - hw/thumb_ctrl_pkg.sv
  - hw/op_decoder.sv
  - hw/reg_list_sequencer.sv
  - hw/thumb_ctrl.sv
  - target: test
    files:
      - testbench/tb_thumb_ctrl.sv
